//--- spi_wb_bridge.f
logic/wb_pkg.sv
logic/spi_pkg.sv
logic/wb_if.sv
logic/spi_byte_rx.sv
logic/spi_byte_tx.sv
logic/cdc_byte_import.sv
logic/cdc_byte_export.sv
logic/wbm_spi.sv
logic/wb_word_ram.sv
logic/spi_wb_bridge_top.sv
verif/spi_wb_bridge_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run the bridge testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module spi_wb_bridge_tb \
	-f spi_wb_bridge.f -o sim_spi_wb_bridge

./obj_dir/sim_spi_wb_bridge | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

//--- verif/spi_wb_bridge_tb.sv
// ==================================================
// Directed testbench for the SPI to Wishbone bridge
// Acts as the SPI mode 0 master and keeps a model
// of the word memory behind the bridge
// ==================================================
`timescale 1ns/1ps

module spi_wb_bridge_tb;

	localparam int SCK_HALF     = 80;  // 160 ns sck period
	localparam int SDI_DLY      = 2;   // sdi follows falling sck
	localparam int DRV_DLY      = 1;   // After rising wb_clk_i
	localparam int ACK_SCAN_MAX = 16;  // Filler bytes allowed before ACK
	localparam int RAND_FRAMES  = 20;
	localparam logic [31:0] RNG_SEED = 32'hcad45d83;

	logic wb_clk_i;
	logic wb_rst_i;
	logic spi_sck_i;
	logic spi_csn_i;
	logic spi_sdi_i;
	logic spi_sdo_o;

	wb_pkg::wb_data_t model [256]; // Expected memory
	bit               written [256]; // Word holds known data

	spi_wb_bridge_top spi_wb_bridge_top_inst (
		.wb_clk_i  (wb_clk_i),
		.wb_rst_i  (wb_rst_i),
		.spi_sck_i (spi_sck_i),
		.spi_csn_i (spi_csn_i),
		.spi_sdi_i (spi_sdi_i),
		.spi_sdo_o (spi_sdo_o)
	);

	initial begin
		wb_clk_i = 1'b0;
		forever #5 wb_clk_i = ~wb_clk_i;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input spi_pkg::spi_byte_t got, input spi_pkg::spi_byte_t exp,
		input string name);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_word(input wb_pkg::wb_data_t got, input wb_pkg::wb_data_t exp,
		input string name);
		if (got !== exp)
			fail_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Command byte W000SSSS
	function automatic spi_pkg::spi_byte_t make_cmd(input logic we, input wb_pkg::wb_sel_t sel);
		spi_pkg::spi_byte_t cmd;
		cmd = 8'h00;
		cmd[wb_pkg::CMD_WE_BIT] = we;
		cmd[wb_pkg::CMD_SEL_HI:wb_pkg::CMD_SEL_LO] = sel;
		return cmd;
	endfunction

	// Byte lanes with sel set take the new data
	function automatic wb_pkg::wb_data_t merge_lanes(input wb_pkg::wb_data_t old_w,
		input wb_pkg::wb_data_t new_w, input wb_pkg::wb_sel_t sel);
		wb_pkg::wb_data_t res;
		res = old_w;
		for (int i = 0; i < wb_pkg::WB_SEL_W; i++) begin
			if (sel[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

	// One full-duplex byte MSB first
	task automatic shift_byte(input spi_pkg::spi_byte_t tx, output spi_pkg::spi_byte_t rx);
		for (int i = 7; i >= 0; i--) begin
			spi_sdi_i = tx[i];
			#(SCK_HALF - SDI_DLY);
			rx[i] = spi_sdo_o; // Stable since sdo moves on falling sck
			spi_sck_i = 1'b1;
			#(SCK_HALF);
			spi_sck_i = 1'b0;
			#(SDI_DLY);
		end
	endtask

	task automatic send_expect(input spi_pkg::spi_byte_t tx, input spi_pkg::spi_byte_t exp,
		input string name);
		spi_pkg::spi_byte_t rsp;
		shift_byte(tx, rsp);
		check_byte(rsp, exp, name);
	endtask

	task automatic open_frame();
		@(posedge wb_clk_i);
		#DRV_DLY spi_csn_i = 1'b0;
	endtask

	task automatic close_frame();
		repeat (32) @(posedge wb_clk_i); // Last response handshake settles
		#DRV_DLY spi_csn_i = 1'b1;
		repeat (40) @(posedge wb_clk_i);
	endtask

	// Fillers until ACK with only WAIT allowed before it
	task automatic wait_for_ack();
		spi_pkg::spi_byte_t rsp;
		int n;
		n = 0;
		rsp = spi_pkg::RSP_WAIT;
		while (rsp !== spi_pkg::RSP_ACK) begin
			if (n == ACK_SCAN_MAX)
				fail_run("no ACK byte came back within 16 filler bytes");
			shift_byte(spi_pkg::CMD_IDLE, rsp);
			n++;
			if (rsp !== spi_pkg::RSP_ACK && rsp !== spi_pkg::RSP_WAIT)
				fail_run($sformatf("response 0x%h came before the ACK byte instead of WAIT", rsp));
		end
	endtask

	task automatic write_word(input int lead, input wb_pkg::wb_sel_t sel,
		input logic [7:0] widx, input wb_pkg::wb_data_t data);
		open_frame();
		repeat (lead) send_expect(spi_pkg::CMD_IDLE, spi_pkg::RSP_WAIT, "spi_sdo_o (idle)");
		send_expect(make_cmd(1'b1, sel), spi_pkg::RSP_WAIT, "spi_sdo_o (cmd)");
		send_expect(widx, spi_pkg::RSP_WAIT, "spi_sdo_o (adr)");
		for (int i = 3; i >= 0; i--) // MSB first
			send_expect(data[8*i +: 8], spi_pkg::RSP_WAIT, "spi_sdo_o (wdata)");
		wait_for_ack();
		send_expect(spi_pkg::CMD_IDLE, spi_pkg::RSP_WAIT, "spi_sdo_o (after ack)"); // One ACK
		close_frame();
		model[widx] = merge_lanes(model[widx], data, sel);
		if (sel == 4'hF)
			written[widx] = 1'b1;
	endtask

	task automatic read_word(input int lead, input logic [7:0] widx,
		output wb_pkg::wb_data_t data);
		spi_pkg::spi_byte_t rsp;
		open_frame();
		repeat (lead) send_expect(spi_pkg::CMD_IDLE, spi_pkg::RSP_WAIT, "spi_sdo_o (idle)");
		send_expect(make_cmd(1'b0, 4'hF), spi_pkg::RSP_WAIT, "spi_sdo_o (cmd)");
		send_expect(widx, spi_pkg::RSP_WAIT, "spi_sdo_o (adr)");
		wait_for_ack();
		for (int i = 0; i < 4; i++) begin // LSB first
			shift_byte(spi_pkg::CMD_IDLE, rsp);
			data[8*i +: 8] = rsp;
		end
		close_frame();
	endtask

	task automatic read_and_compare(input int lead, input logic [7:0] widx);
		wb_pkg::wb_data_t rd;
		read_word(lead, widx, rd);
		check_word(rd, model[widx], $sformatf("dat_r word 0x%h", widx));
	endtask

	task automatic idle_then_write_ack();
		open_frame();
		repeat (4) send_expect(spi_pkg::CMD_IDLE, spi_pkg::RSP_WAIT, "spi_sdo_o (idle frame)");
		close_frame();
		write_word(0, 4'hF, 8'h10, 32'h1234_5678);
	endtask

	task automatic full_word_round_trip();
		write_word(0, 4'hF, 8'h22, 32'h3c5a_96e1); // Even word with short ack
		write_word(0, 4'hF, 8'h23, 32'h7e01_c3a4); // Odd word with long ack
		read_and_compare(0, 8'h22);
		read_and_compare(0, 8'h23);
	endtask

	task automatic partial_write_merge();
		wb_pkg::wb_data_t rd;
		write_word(0, 4'hF, 8'h41, 32'h1122_3344);
		write_word(0, 4'h5, 8'h41, 32'haabb_ccdd); // Bytes 0 and 2
		read_word(0, 8'h41, rd);
		check_word(rd, 32'h11bb_33dd, "dat_r word 0x41");
	endtask

	task automatic random_traffic();
		logic [31:0]      r;
		logic [7:0]       widx;
		wb_pkg::wb_sel_t  sel;
		wb_pkg::wb_data_t data;
		for (int i = 0; i < RAND_FRAMES; i++) begin
			r    = $urandom();
			widx = {r[7:1], i[0]}; // Alternate even and odd words
			sel  = r[11:8];
			data = $urandom();
			if (!written[widx])
				sel = 4'hF; // Unknown word gets a full write first
			write_word(0, sel, widx, data);
			read_and_compare(0, widx);
		end
	endtask

	task automatic idle_prefix_skip();
		write_word(3, 4'hF, 8'h80, 32'h5a0f_e1c7);
		read_and_compare(2, 8'h80);
	endtask

	initial begin
		wb_rst_i  = 1'b1;
		spi_sck_i = 1'b0; // Mode 0 idle level
		spi_csn_i = 1'b0; // Raised below so that the edge clears the SPI side
		spi_sdi_i = 1'b0;
		void'($urandom(RNG_SEED));
		for (int i = 0; i < 256; i++) begin
			model[i]   = 32'h0;
			written[i] = 1'b0;
		end
		@(posedge wb_clk_i);
		#DRV_DLY spi_csn_i = 1'b1;
		repeat (2) @(posedge wb_clk_i);
		#DRV_DLY wb_rst_i = 1'b0; // Three cycles of reset
		repeat (10) @(posedge wb_clk_i);

		idle_then_write_ack();
		full_word_round_trip();
		partial_write_merge();
		random_traffic();
		idle_prefix_skip();

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- logic/spi_wb_bridge_top.sv
// ==================================================
// SPI to Wishbone bridge with its word memory
// ==================================================
`timescale 1ns/1ps

module spi_wb_bridge_top (
	input  logic wb_clk_i,
	input  logic wb_rst_i,
	input  logic spi_sck_i,
	input  logic spi_csn_i,
	input  logic spi_sdi_i,
	output logic spi_sdo_o
);

	wb_if wb_bus (); // Master to memory

	wbm_spi wbm_spi_inst (
		.wb_clk_i  (wb_clk_i),
		.wb_rst_i  (wb_rst_i),
		.wb        (wb_bus.master),
		.spi_sck_i (spi_sck_i),
		.spi_csn_i (spi_csn_i),
		.spi_sdi_i (spi_sdi_i),
		.spi_sdo_o (spi_sdo_o)
	);

	wb_word_ram wb_word_ram_inst (
		.wb_clk_i (wb_clk_i),
		.wb_rst_i (wb_rst_i),
		.wb       (wb_bus.slave)
	);

endmodule

//--- logic/wb_word_ram.sv
// ==================================================
// Wishbone B4 pipelined word memory, 256 words
// Stalls each request once, acks after 1 cycle on
// even words and 3 cycles on odd ones
// ==================================================
`timescale 1ns/1ps

module wb_word_ram (
	input  logic wb_clk_i,
	input  logic wb_rst_i,
	wb_if.slave  wb
);

	localparam int DEPTH = 2 ** wb_pkg::WB_RAM_AW;

	wb_pkg::wb_data_t                mem [DEPTH];
	logic [wb_pkg::WB_RAM_AW-1:0]    idx;     // Word index
	logic                            seen_q;  // Request already stalled once
	logic                            accept;
	logic [1:0]                      dly_cnt; // Cycles left before ack

	assign idx      = wb.adr[wb_pkg::WB_RAM_AW+1:2];
	assign wb.stall = wb.stb & ~seen_q; // First cycle of every request
	assign accept   = wb.cyc & wb.stb & ~wb.stall;

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			seen_q  <= 1'b0;
			dly_cnt <= 2'd0;
			wb.ack  <= 1'b0;
		end else begin
			seen_q <= wb.stb & ~seen_q;
			wb.ack <= 1'b0;
			if (accept) begin
				dly_cnt <= wb.adr[2] ? 2'd2 : 2'd0; // Odd word waits longer
				wb.ack  <= ~wb.adr[2];
			end else if (dly_cnt != 2'd0) begin
				dly_cnt <= dly_cnt - 2'd1;
				wb.ack  <= (dly_cnt == 2'd1);
			end
		end
	end

	// Array access at acceptance, read word held until ack
	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			wb.dat_r <= mem[idx];
			if (wb.we) begin
				for (int i = 0; i < wb_pkg::WB_SEL_W; i++) begin
					if (wb.sel[i])
						mem[idx][8*i +: 8] <= wb.dat_w[8*i +: 8];
				end
			end
		end
	end

endmodule

//--- logic/wbm_spi.sv
// ==================================================
// SPI controlled Wishbone B4 pipelined master
// Decodes W000SSSS / address / data frames into one
// single-word transfer and returns WAIT, ACK, data
// ==================================================
`timescale 1ns/1ps

module wbm_spi (
	input  logic wb_clk_i,
	input  logic wb_rst_i,
	wb_if.master wb,
	input  logic spi_sck_i,
	input  logic spi_csn_i,
	input  logic spi_sdi_i,
	output logic spi_sdo_o
);

	logic                 rx_req;
	logic                 rx_ack;
	spi_pkg::spi_byte_t   rx_data;
	logic                 rx_stb;    // One cycle per received byte
	spi_pkg::spi_byte_t   rx_byte;
	logic                 tx_req;
	logic                 tx_ack;
	spi_pkg::spi_byte_t   tx_data;
	logic                 load_stb;  // Response load, one cycle after rx_stb
	spi_pkg::spi_byte_t   load_byte; // Response for the next SPI byte
	wb_pkg::wbm_state_t   state;
	wb_pkg::wb_data_t     rd_data;   // Read word, drained LSB first

	spi_byte_rx spi_byte_rx_inst (
		.spi_sck_i (spi_sck_i),
		.spi_csn_i (spi_csn_i),
		.spi_sdi_i (spi_sdi_i),
		.rx_req_o  (rx_req),
		.rx_ack_i  (rx_ack),
		.rx_data_o (rx_data)
	);

	cdc_byte_import cdc_byte_import_inst (
		.wb_clk_i   (wb_clk_i),
		.wb_rst_i   (wb_rst_i),
		.rx_req_i   (rx_req),
		.rx_ack_o   (rx_ack),
		.rx_data_i  (rx_data),
		.byte_stb_o (rx_stb),
		.byte_o     (rx_byte)
	);

	cdc_byte_export cdc_byte_export_inst (
		.wb_clk_i    (wb_clk_i),
		.wb_rst_i    (wb_rst_i),
		.load_i      (load_stb),
		.load_data_i (load_byte),
		.tx_req_o    (tx_req),
		.tx_ack_i    (tx_ack),
		.tx_data_o   (tx_data)
	);

	spi_byte_tx spi_byte_tx_inst (
		.spi_sck_i (spi_sck_i),
		.spi_csn_i (spi_csn_i),
		.spi_sdo_o (spi_sdo_o),
		.tx_req_i  (tx_req),
		.tx_ack_o  (tx_ack),
		.tx_data_i (tx_data)
	);

	// FSM, bus handshake and response byte
	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			state     <= wb_pkg::GET_COMMAND;
			wb.cyc    <= 1'b0;
			wb.stb    <= 1'b0;
			load_stb  <= 1'b0;
			load_byte <= spi_pkg::RSP_WAIT;
		end else begin
			load_stb <= rx_stb; // Every byte gets a response
			if (wb.stb && !wb.stall)
				wb.stb <= 1'b0; // Accepted
			if (wb.ack)
				wb.cyc <= 1'b0;
			if (rx_stb) begin
				case (state)
				wb_pkg::GET_COMMAND: begin
					load_byte <= spi_pkg::RSP_WAIT;
					if (rx_byte != spi_pkg::CMD_IDLE)
						state <= wb_pkg::GET_ADDRESS;
				end
				wb_pkg::GET_ADDRESS: begin
					if (wb.we) begin
						state <= wb_pkg::WRITE_DATA_0;
					end else begin
						wb.cyc <= 1'b1; // Read starts right away
						wb.stb <= 1'b1;
						state  <= wb_pkg::READ_WAIT_ACK;
					end
				end
				wb_pkg::READ_WAIT_ACK: begin
					if (!wb.cyc) begin
						load_byte <= spi_pkg::RSP_ACK;
						state     <= wb_pkg::READ_DATA_0;
					end
				end
				wb_pkg::READ_DATA_0: begin
					load_byte <= rd_data[7:0];
					state     <= wb_pkg::READ_DATA_1;
				end
				wb_pkg::READ_DATA_1: begin
					load_byte <= rd_data[7:0];
					state     <= wb_pkg::READ_DATA_2;
				end
				wb_pkg::READ_DATA_2: begin
					load_byte <= rd_data[7:0];
					state     <= wb_pkg::READ_DATA_3;
				end
				wb_pkg::READ_DATA_3: begin
					load_byte <= rd_data[7:0]; // Last byte, MSB of the word
					state     <= wb_pkg::GET_COMMAND;
				end
				wb_pkg::WRITE_DATA_0: state <= wb_pkg::WRITE_DATA_1;
				wb_pkg::WRITE_DATA_1: state <= wb_pkg::WRITE_DATA_2;
				wb_pkg::WRITE_DATA_2: state <= wb_pkg::WRITE_DATA_3;
				wb_pkg::WRITE_DATA_3: begin
					wb.cyc <= 1'b1; // Word complete
					wb.stb <= 1'b1;
					state  <= wb_pkg::WRITE_WAIT_ACK;
				end
				wb_pkg::WRITE_WAIT_ACK: begin
					if (!wb.cyc) begin
						load_byte <= spi_pkg::RSP_ACK;
						state     <= wb_pkg::GET_COMMAND;
					end
				end
				default: state <= wb_pkg::GET_COMMAND;
				endcase
			end
		end
	end

	// Request fields and data path
	always_ff @(posedge wb_clk_i) begin
		if (wb.ack)
			rd_data <= wb.dat_r;
		if (rx_stb) begin
			case (state)
			wb_pkg::GET_COMMAND: begin
				wb.we  <= rx_byte[wb_pkg::CMD_WE_BIT];
				wb.sel <= rx_byte[wb_pkg::CMD_SEL_HI:wb_pkg::CMD_SEL_LO];
			end
			wb_pkg::GET_ADDRESS: // Word address to byte address
				wb.adr <= {{(wb_pkg::WB_ADR_W - 10){1'b0}}, rx_byte, 2'b00};
			wb_pkg::READ_DATA_0, wb_pkg::READ_DATA_1, wb_pkg::READ_DATA_2:
				rd_data <= {8'h00, rd_data[wb_pkg::WB_DATA_W-1:8]};
			wb_pkg::WRITE_DATA_0, wb_pkg::WRITE_DATA_1,
			wb_pkg::WRITE_DATA_2, wb_pkg::WRITE_DATA_3: // MSB first
				wb.dat_w <= {wb.dat_w[wb_pkg::WB_DATA_W-9:0], rx_byte};
			default: ;
			endcase
		end
	end

endmodule

//--- logic/cdc_byte_export.sv
// ==================================================
// Transmit byte crossing out of wb_clk_i
// Launches loaded bytes over four-phase req/ack,
// keeping only the newest one while busy
// ==================================================
`timescale 1ns/1ps

module cdc_byte_export (
	input  logic               wb_clk_i,
	input  logic               wb_rst_i,
	input  logic               load_i,
	input  spi_pkg::spi_byte_t load_data_i,
	output logic               tx_req_o,
	input  logic               tx_ack_i,
	output spi_pkg::spi_byte_t tx_data_o
);

	logic [1:0]         ack_sync;  // Two-flop synchronizer
	logic               pending;   // Byte waiting for a free channel
	spi_pkg::spi_byte_t pend_data;
	logic               idle;      // All four phases closed

	assign idle = ~tx_req_o & ~ack_sync[1];

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			ack_sync <= 2'b00;
			pending  <= 1'b0;
			tx_req_o <= 1'b0;
		end else begin
			ack_sync <= {ack_sync[0], tx_ack_i};
			if (tx_req_o && ack_sync[1])
				tx_req_o <= 1'b0;          // Phase 3
			if (load_i && idle) begin
				tx_data_o <= load_data_i;  // Req one cycle after load
				tx_req_o  <= 1'b1;
				pending   <= 1'b0;
			end else if (load_i) begin
				pend_data <= load_data_i;  // Newer byte replaces older
				pending   <= 1'b1;
			end else if (pending && idle) begin
				tx_data_o <= pend_data;
				tx_req_o  <= 1'b1;
				pending   <= 1'b0;
			end
		end
	end

endmodule

//--- logic/cdc_byte_import.sv
// ==================================================
// Receive byte crossing into wb_clk_i
// Synchronizes rx req, answers with ack and gives
// a one-cycle strobe with the byte
// ==================================================
`timescale 1ns/1ps

module cdc_byte_import (
	input  logic               wb_clk_i,
	input  logic               wb_rst_i,
	input  logic               rx_req_i,
	output logic               rx_ack_o,
	input  spi_pkg::spi_byte_t rx_data_i,
	output logic               byte_stb_o,
	output spi_pkg::spi_byte_t byte_o
);

	logic [1:0] req_sync; // Two-flop synchronizer

	always_ff @(posedge wb_clk_i) begin
		if (wb_rst_i) begin
			req_sync   <= 2'b00;
			rx_ack_o   <= 1'b0;
			byte_stb_o <= 1'b0;
		end else begin
			req_sync   <= {req_sync[0], rx_req_i};
			rx_ack_o   <= req_sync[1];                // Follows req both ways
			byte_stb_o <= req_sync[1] & ~rx_ack_o;    // Rising req, 3 cycles in
		end
	end

	// Data has been stable since req rose
	always_ff @(posedge wb_clk_i) begin
		if (req_sync[1] && !rx_ack_o)
			byte_o <= rx_data_i;
	end

endmodule

//--- logic/spi_byte_tx.sv
// ==================================================
// SPI mode 0 byte transmitter
// Takes response bytes over four-phase req/ack and
// shifts them out on falling sck, MSB first
// ==================================================
`timescale 1ns/1ps

module spi_byte_tx (
	input  logic               spi_sck_i,
	input  logic               spi_csn_i,
	output logic               spi_sdo_o,
	input  logic               tx_req_i,
	output logic               tx_ack_o,
	input  spi_pkg::spi_byte_t tx_data_i
);

	logic [2:0]         bit_cnt; // Falling edges in the current byte
	spi_pkg::spi_byte_t shadow;  // Last byte taken from the channel
	spi_pkg::spi_byte_t shift;   // Byte on the wire
	logic               take;    // Open request seen on this edge

	assign take = tx_req_i & ~tx_ack_o;

	always_ff @(negedge spi_sck_i or posedge spi_csn_i) begin
		if (spi_csn_i) begin
			bit_cnt  <= 3'd0;
			shadow   <= spi_pkg::RSP_WAIT;
			shift    <= spi_pkg::RSP_WAIT; // First byte of a frame reads WAIT
			tx_ack_o <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1;
			if (take) begin
				shadow   <= tx_data_i;
				tx_ack_o <= 1'b1;
			end else if (!tx_req_i && tx_ack_o) begin
				tx_ack_o <= 1'b0; // Phase 4
			end
			// Byte boundary: falling edge after the 8th rising edge
			if (bit_cnt == 3'd7)
				shift <= take ? tx_data_i : shadow; // Late byte repeats last value
			else
				shift <= {shift[6:0], 1'b1};
		end
	end

	assign spi_sdo_o = shift[7]; // MSB first

endmodule

//--- logic/spi_byte_rx.sv
// ==================================================
// SPI mode 0 byte receiver
// Shifts sdi in on rising sck, MSB first, and offers
// each full byte over a four-phase req/ack channel
// ==================================================
`timescale 1ns/1ps

module spi_byte_rx (
	input  logic               spi_sck_i,
	input  logic               spi_csn_i,
	input  logic               spi_sdi_i,
	output logic               rx_req_o,
	input  logic               rx_ack_i,
	output spi_pkg::spi_byte_t rx_data_o
);

	logic [2:0] bit_cnt; // Bits taken in the current byte
	logic [6:0] shift;   // First seven bits of the byte

	// No sck while csn is high, so csn clears the domain
	always_ff @(posedge spi_sck_i or posedge spi_csn_i) begin
		if (spi_csn_i) begin
			bit_cnt  <= 3'd0;
			shift    <= 7'd0;
			rx_req_o <= 1'b0;
		end else begin
			bit_cnt <= bit_cnt + 3'd1; // Wraps after the eighth bit
			shift   <= {shift[5:0], spi_sdi_i};
			if (bit_cnt == 3'd7)
				rx_req_o <= 1'b1;  // Byte complete on 8th edge
			else if (rx_ack_i)
				rx_req_o <= 1'b0;  // Phase 3
		end
	end

	// Completed byte
	// held for eight more edges, well past the handshake
	always_ff @(posedge spi_sck_i) begin
		if (bit_cnt == 3'd7)
			rx_data_o <= {shift, spi_sdi_i};
	end

endmodule

//--- logic/wb_if.sv
// ==================================================
// Wishbone B4 pipelined bus, one request channel
// with master and slave views
// ==================================================
`timescale 1ns/1ps

interface wb_if;

	logic              cyc;   // Bus cycle in progress
	logic              stb;   // Request valid
	logic              we;    // Write when high
	wb_pkg::wb_sel_t   sel;   // Byte lanes
	wb_pkg::wb_adr_t   adr;   // Byte address
	wb_pkg::wb_data_t  dat_w; // Master to slave
	wb_pkg::wb_data_t  dat_r; // Slave to master, valid with ack
	logic              stall; // Request not taken this cycle
	logic              ack;   // Transfer done

	modport master (
		output cyc, stb, we, sel, adr, dat_w,
		input  dat_r, stall, ack
	);

	modport slave (
		input  cyc, stb, we, sel, adr, dat_w,
		output dat_r, stall, ack
	);

endinterface

//--- logic/spi_pkg.sv
// ==================================================
// SPI byte type and response byte codes
// ==================================================
package spi_pkg;

	localparam int SPI_BYTE_W = 8;

	typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

	// Shifted out while the Wishbone transfer is pending
	localparam spi_byte_t RSP_WAIT = 8'hFF;

	// Marks the arrival of the Wishbone ack
	localparam spi_byte_t RSP_ACK = 8'h00;

	// Filler command, skipped by the frame decoder
	localparam spi_byte_t CMD_IDLE = 8'h00;

endpackage

//--- logic/wb_pkg.sv
// ==================================================
// Wishbone bus widths, command byte fields and
// the state encoding of the SPI driven master
// ==================================================
package wb_pkg;

	localparam int WB_DATA_W = 32; // Data word
	localparam int WB_ADR_W  = 16; // Byte address
	localparam int WB_SEL_W  = WB_DATA_W / 8;
	localparam int WB_RAM_AW = 8;  // Word index bits of the memory

	typedef logic [WB_DATA_W-1:0] wb_data_t;
	typedef logic [WB_ADR_W-1:0]  wb_adr_t;
	typedef logic [WB_SEL_W-1:0]  wb_sel_t;

	// Command byte W000SSSS
	localparam int CMD_WE_BIT = 7;
	localparam int CMD_SEL_HI = 3;
	localparam int CMD_SEL_LO = 0;

	typedef enum logic [3:0] {
		GET_COMMAND, GET_ADDRESS, READ_WAIT_ACK,
		READ_DATA_0, READ_DATA_1, READ_DATA_2, READ_DATA_3,
		WRITE_DATA_0, WRITE_DATA_1, WRITE_DATA_2, WRITE_DATA_3,
		WRITE_WAIT_ACK
	} wbm_state_t;

endpackage
